//--- Bender.yml
package:
  name: ecc_mem

sources:
  - include_dirs:
      - include
    files:
      - logic/ecc_mem_pkg.sv
      - logic/ecc_13_codec.sv
      - logic/ecc_mem_array.sv
      - logic/ecc_err_log.sv
      - logic/ecc_wb_slave.sv
      - logic/ecc_mem_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/ecc_mem_tb.sv

//--- bench/ecc_mem_tb.sv
`default_nettype none

`include "ecc_mem_settings.svh"

module ecc_mem_tb;

    import ecc_mem_pkg::*;

    localparam int resp_limit = 8;
    localparam int max_cycles = 4000; // about ten times the test length.

    logic        clk;
    logic        rst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    int          cycle_count;
    integer      seed;
    int          sbit_exp;
    int          dbit_exp;
    logic [12:0] vals [8];
    logic [12:0] v;

    ecc_mem_top u_ecc_mem_top (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_stop(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic expect_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act === exp) else
            fail_stop($sformatf("FAIL %s expected %0h actual %0h", name, exp, act));
    endtask

    function automatic logic [`ECC_MEM_AW:0] csr_adr(input logic [2:0] off);
        csr_adr = '0;
        csr_adr[`ECC_CSR_SEL] = 1'b1;
        csr_adr[2:0] = off;
    endfunction

    // response is sampled on the falling edge and stb drops on the next rising one.
    task automatic wait_response(output wb_rsp_t rsp, output int lat);
        lat = 0;
        @(negedge clk);
        while (!(wb_rsp.ack || wb_rsp.err)) begin
            lat++;
            if (lat > resp_limit) begin
                fail_stop("no ack or err arrived within 8 cycles of the strobe");
            end
            @(negedge clk);
        end
        rsp = wb_rsp;
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic write_cycle(input logic [`ECC_MEM_AW:0] adr, input logic [15:0] dat);
        wb_rsp_t rsp;
        int      lat;
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
        wait_response(rsp, lat);
        expect_value("wb_rsp.ack", 1, rsp.ack);
        expect_value("wb_rsp.err", 0, rsp.err);
        expect_value("write latency", 1, lat);
    endtask

    task automatic read_cycle(input logic [`ECC_MEM_AW:0] adr, output wb_rsp_t rsp,
                              output int lat);
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0};
        wait_response(rsp, lat);
    endtask

    task automatic set_reg(input logic [2:0] off, input logic [15:0] val);
        write_cycle(csr_adr(off), val);
    endtask

    task automatic store_word(input logic [5:0] a, input logic [12:0] val);
        write_cycle({1'b0, a}, {3'b0, val});
    endtask

    task automatic reg_readback(input string name, input logic [2:0] off,
                                input logic [15:0] exp);
        wb_rsp_t rsp;
        int      lat;
        read_cycle(csr_adr(off), rsp, lat);
        expect_value("wb_rsp.ack", 1, rsp.ack);
        expect_value("wb_rsp.err", 0, rsp.err);
        expect_value("register read latency", 1, lat);
        expect_value(name, exp, rsp.dat);
    endtask

    task automatic mem_readback(input logic [5:0] a, input logic [12:0] exp);
        wb_rsp_t rsp;
        int      lat;
        read_cycle({1'b0, a}, rsp, lat);
        expect_value("wb_rsp.ack", 1, rsp.ack);
        expect_value("wb_rsp.err", 0, rsp.err);
        expect_value("memory read latency", 2, lat);
        expect_value("wb_rsp.dat", {3'b0, exp}, rsp.dat); // upper bits zero.
    endtask

    task automatic mem_uncorrectable(input logic [5:0] a);
        wb_rsp_t rsp;
        int      lat;
        read_cycle({1'b0, a}, rsp, lat);
        expect_value("wb_rsp.err", 1, rsp.err);
        expect_value("wb_rsp.ack", 0, rsp.ack);
        expect_value("memory read latency", 2, lat);
    endtask

    task automatic counters_are(input int sbit, input int dbit);
        reg_readback("sbit_cnt", `ECC_REG_SBIT_CNT, sbit[15:0]);
        reg_readback("dbit_cnt", `ECC_REG_DBIT_CNT, dbit[15:0]);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            fail_stop("run did not finish within the cycle limit");
        end
    end

    initial begin
        cycle_count = 0;
        sbit_exp = 0;
        dbit_exp = 0;
        seed = 32'hc340_f642;
        rst_n <= 1'b0;
        wb_req <= '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // clean round trip.
        for (int i = 0; i < 8; i++) begin
            vals[i] = $random(seed);
            store_word(6'(i * 9), vals[i]);
        end
        for (int i = 0; i < 8; i++) begin
            mem_readback(6'(i * 9), vals[i]);
        end
        counters_are(0, 0);

        // each data bit corrected in turn.
        for (int b = 0; b < 13; b++) begin
            v = $random(seed);
            set_reg(`ECC_REG_FLIP_DATA, 16'd1 << b);
            store_word(6'(32 + b), v);
            set_reg(`ECC_REG_FLIP_DATA, 16'd0);
            mem_readback(6'(32 + b), v);
            sbit_exp++;
            reg_readback("sbit_cnt", `ECC_REG_SBIT_CNT, sbit_exp[15:0]);
            reg_readback("last_adr", `ECC_REG_LAST_ADR, 16'(32 + b));
        end

        for (int b = 0; b < 6; b++) begin
            v = $random(seed);
            set_reg(`ECC_REG_FLIP_PAR, 16'd1 << b);
            store_word(6'(48 + b), v);
            set_reg(`ECC_REG_FLIP_PAR, 16'd0);
            mem_readback(6'(48 + b), v); // check bit hit leaves data untouched.
            sbit_exp++;
            reg_readback("sbit_cnt", `ECC_REG_SBIT_CNT, sbit_exp[15:0]);
        end

        // two data bits.
        v = $random(seed);
        set_reg(`ECC_REG_FLIP_DATA, 16'h0204);
        store_word(6'd60, v);
        set_reg(`ECC_REG_FLIP_DATA, 16'd0);
        mem_uncorrectable(6'd60);
        dbit_exp++;
        counters_are(sbit_exp, dbit_exp);
        reg_readback("last_adr", `ECC_REG_LAST_ADR, 16'd60);

        // one data bit and one check bit.
        v = $random(seed);
        set_reg(`ECC_REG_FLIP_DATA, 16'h0001);
        set_reg(`ECC_REG_FLIP_PAR, 16'h0008);
        store_word(6'd61, v);
        set_reg(`ECC_REG_FLIP_DATA, 16'd0);
        set_reg(`ECC_REG_FLIP_PAR, 16'd0);
        mem_uncorrectable(6'd61);
        dbit_exp++;
        counters_are(sbit_exp, dbit_exp);
        reg_readback("last_adr", `ECC_REG_LAST_ADR, 16'd61);

        // bypass shows the raw stored word.
        v = $random(seed);
        set_reg(`ECC_REG_CTRL, 16'd1);
        reg_readback("bypass", `ECC_REG_CTRL, 16'd1);
        set_reg(`ECC_REG_FLIP_DATA, 16'h0080);
        store_word(6'd62, v);
        set_reg(`ECC_REG_FLIP_DATA, 16'd0);
        mem_readback(6'd62, v ^ 13'h0080);
        counters_are(sbit_exp, dbit_exp);
        set_reg(`ECC_REG_CTRL, 16'd0);
        mem_readback(6'd62, v);
        sbit_exp++;
        counters_are(sbit_exp, dbit_exp);

        set_reg(`ECC_REG_SBIT_CNT, 16'hffff);
        set_reg(`ECC_REG_DBIT_CNT, 16'hffff);
        counters_are(0, 0);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- ecc_mem_top.f
+incdir+include
logic/ecc_mem_pkg.sv
logic/ecc_13_codec.sv
logic/ecc_mem_array.sv
logic/ecc_err_log.sv
logic/ecc_wb_slave.sv
logic/ecc_mem_top.sv
bench/ecc_mem_tb.sv

//--- include/ecc_mem_settings.svh
`ifndef ECC_MEM_SETTINGS_SVH
`define ECC_MEM_SETTINGS_SVH

// memory geometry.
`define ECC_MEM_DEPTH 64
`define ECC_MEM_AW 6

`define ECC_WB_DW 16

// adr bit that selects register space.
`define ECC_CSR_SEL 6

`define ECC_REG_CTRL      3'd0
`define ECC_REG_FLIP_DATA 3'd1
`define ECC_REG_FLIP_PAR  3'd2
`define ECC_REG_SBIT_CNT  3'd3
`define ECC_REG_DBIT_CNT  3'd4
`define ECC_REG_LAST_ADR  3'd5

`endif

//--- logic/ecc_13_codec.sv
`default_nettype none

module ecc_13_codec (
    input  wire logic [12:0]              data_in,
    input  wire logic [5:0]               parity_in,
    input  wire logic                     bypass,
    output logic [12:0]                   data_out,
    output logic [5:0]                    parity_out,
    output ecc_mem_pkg::ecc_status_t      status
);

    logic [5:0]  syndrome;
    logic [12:0] fix_mask;
    logic        sbit_raw;
    logic        dbit_raw;

    // fixed hamming columns of odd weight.
    function automatic logic [5:0] encode(input logic [12:0] d);
        logic [5:0] p;
        p[0] = ^{d[0], d[1], d[3], d[4], d[6], d[8], d[10], d[11]};
        p[1] = ^{d[0], d[2], d[3], d[5], d[6], d[9], d[10], d[12]};
        p[2] = ^{d[1], d[2], d[3], d[7], d[8], d[9], d[10]};
        p[3] = ^{d[4], d[5], d[6], d[7], d[8], d[9], d[10]};
        p[4] = ^{d[11], d[12]};
        p[5] = ^{d[0], d[1], d[2], d[4], d[5], d[7], d[10], d[11], d[12]};
        return p;
    endfunction

    assign parity_out = encode(data_in);
    assign syndrome   = parity_in ^ parity_out;

    always_comb begin
        fix_mask = '0;
        sbit_raw = 1'b0;
        dbit_raw = 1'b0;
        case (syndrome)
            6'b000000: ;
            6'b100011: fix_mask[0]  = 1'b1;
            6'b100101: fix_mask[1]  = 1'b1;
            6'b100110: fix_mask[2]  = 1'b1;
            6'b000111: fix_mask[3]  = 1'b1;
            6'b101001: fix_mask[4]  = 1'b1;
            6'b101010: fix_mask[5]  = 1'b1;
            6'b001011: fix_mask[6]  = 1'b1;
            6'b101100: fix_mask[7]  = 1'b1;
            6'b001101: fix_mask[8]  = 1'b1;
            6'b001110: fix_mask[9]  = 1'b1;
            6'b101111: fix_mask[10] = 1'b1;
            6'b110001: fix_mask[11] = 1'b1;
            6'b110010: fix_mask[12] = 1'b1;
            default: begin
                if ($onehot(syndrome)) begin
                    sbit_raw = 1'b1; // only a check bit was hit.
                end else begin
                    dbit_raw = 1'b1;
                end
            end
        endcase
        sbit_raw = sbit_raw | (|fix_mask);
    end

    assign data_out = bypass ? data_in : data_in ^ fix_mask;
    assign status   = '{sbit: sbit_raw & ~bypass, dbit: dbit_raw & ~bypass};

    a_status_excl: assert final (!(status.sbit && status.dbit));

endmodule

`default_nettype wire

//--- logic/ecc_err_log.sv
`default_nettype none

`include "ecc_mem_settings.svh"

module ecc_err_log (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    log_sbit,
    input  wire logic                    log_dbit,
    input  wire logic [`ECC_MEM_AW-1:0]  log_adr,
    input  wire logic                    clear_sbit,
    input  wire logic                    clear_dbit,
    output logic [`ECC_WB_DW-1:0]        sbit_cnt,
    output logic [`ECC_WB_DW-1:0]        dbit_cnt,
    output logic [`ECC_MEM_AW-1:0]       last_adr
);

    // clear wins, then saturate at all ones.
    function automatic logic [`ECC_WB_DW-1:0] cnt_next(
        input logic [`ECC_WB_DW-1:0] cnt,
        input logic                  clr,
        input logic                  inc
    );
        if (clr) begin
            return '0;
        end
        if (inc && cnt != '1) begin
            return cnt + 1'b1;
        end
        return cnt;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sbit_cnt <= '0;
            dbit_cnt <= '0;
            last_adr <= '0;
        end else begin
            sbit_cnt <= cnt_next(sbit_cnt, clear_sbit, log_sbit);
            dbit_cnt <= cnt_next(dbit_cnt, clear_dbit, log_dbit);
            if (log_sbit || log_dbit) begin
                last_adr <= log_adr;
            end
        end
    end

    // one read yields one classification.
    a_one_log: assert property (
        @(posedge clk) disable iff (!rst_n) !(log_sbit && log_dbit)
    );

endmodule

`default_nettype wire

//--- logic/ecc_mem_array.sv
`default_nettype none

`include "ecc_mem_settings.svh"

module ecc_mem_array (
    input  wire logic                    clk,
    input  wire logic                    we,
    input  wire logic [`ECC_MEM_AW-1:0]  adr,
    input  wire ecc_mem_pkg::ecc_word_t  wdata,
    output ecc_mem_pkg::ecc_word_t       rdata
);

    import ecc_mem_pkg::*;

    ecc_word_t mem [`ECC_MEM_DEPTH];

    // read port sees the old word on a same-cycle write.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[adr] <= wdata;
        end
        rdata <= mem[adr];
    end

    a_adr_range: assert property (
        @(posedge clk) we |-> (adr < `ECC_MEM_DEPTH)
    );

endmodule

`default_nettype wire

//--- logic/ecc_mem_pkg.sv
`default_nettype none

`include "ecc_mem_settings.svh"

package ecc_mem_pkg;

    // master to slave, classic cycle.
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`ECC_MEM_AW:0]  adr; // top bit is the register select.
        logic [`ECC_WB_DW-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                  ack;
        logic                  err;
        logic [`ECC_WB_DW-1:0] dat;
    } wb_rsp_t;

    // one stored word.
    typedef struct packed {
        logic [5:0]  parity;
        logic [12:0] data;
    } ecc_word_t;

    typedef struct packed {
        logic sbit;
        logic dbit;
    } ecc_status_t;

    typedef enum logic [1:0] {
        IDLE,
        READ_WAIT,
        RESPOND
    } slave_state_t;

endpackage

`default_nettype wire

//--- logic/ecc_mem_top.sv
`default_nettype none

`include "ecc_mem_settings.svh"

module ecc_mem_top (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire ecc_mem_pkg::wb_req_t  wb_req,
    output ecc_mem_pkg::wb_rsp_t       wb_rsp
);

    import ecc_mem_pkg::*;

    logic                   mem_we;
    logic [`ECC_MEM_AW-1:0] mem_adr;
    ecc_word_t              wr_word;
    ecc_word_t              rd_word;
    logic [12:0]            enc_data;
    logic [5:0]             enc_parity;
    logic [12:0]            dec_data;
    ecc_status_t            dec_status;
    logic                   bypass;
    logic                   log_sbit;
    logic                   log_dbit;
    logic [`ECC_MEM_AW-1:0] log_adr;
    logic                   clear_sbit;
    logic                   clear_dbit;
    logic [`ECC_WB_DW-1:0]  sbit_cnt;
    logic [`ECC_WB_DW-1:0]  dbit_cnt;
    logic [`ECC_MEM_AW-1:0] last_adr;

    ecc_wb_slave u_slave (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .mem_we     (mem_we),
        .mem_adr    (mem_adr),
        .mem_wdata  (wr_word),
        .enc_data   (enc_data),
        .enc_parity (enc_parity),
        .dec_data   (dec_data),
        .dec_status (dec_status),
        .bypass     (bypass),
        .log_sbit   (log_sbit),
        .log_dbit   (log_dbit),
        .log_adr    (log_adr),
        .clear_sbit (clear_sbit),
        .clear_dbit (clear_dbit),
        .sbit_cnt   (sbit_cnt),
        .dbit_cnt   (dbit_cnt),
        .last_adr   (last_adr)
    );

    // encoder only, syndrome side unused.
    ecc_13_codec u_enc (
        .data_in    (enc_data),
        .parity_in  (6'b0),
        .bypass     (1'b0),
        .data_out   (),
        .parity_out (enc_parity),
        .status     ()
    );

    ecc_13_codec u_dec (
        .data_in    (rd_word.data),
        .parity_in  (rd_word.parity),
        .bypass     (bypass),
        .data_out   (dec_data),
        .parity_out (),
        .status     (dec_status)
    );

    ecc_mem_array u_array (
        .clk   (clk),
        .we    (mem_we),
        .adr   (mem_adr),
        .wdata (wr_word),
        .rdata (rd_word)
    );

    ecc_err_log u_log (
        .clk        (clk),
        .rst_n      (rst_n),
        .log_sbit   (log_sbit),
        .log_dbit   (log_dbit),
        .log_adr    (log_adr),
        .clear_sbit (clear_sbit),
        .clear_dbit (clear_dbit),
        .sbit_cnt   (sbit_cnt),
        .dbit_cnt   (dbit_cnt),
        .last_adr   (last_adr)
    );

endmodule

`default_nettype wire

//--- logic/ecc_wb_slave.sv
`default_nettype none

`include "ecc_mem_settings.svh"

module ecc_wb_slave (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire ecc_mem_pkg::wb_req_t      wb_req,
    output ecc_mem_pkg::wb_rsp_t           wb_rsp,
    output logic                           mem_we,
    output logic [`ECC_MEM_AW-1:0]         mem_adr,
    output ecc_mem_pkg::ecc_word_t         mem_wdata,
    output logic [12:0]                    enc_data,
    input  wire logic [5:0]                enc_parity,
    input  wire logic [12:0]               dec_data,
    input  wire ecc_mem_pkg::ecc_status_t  dec_status,
    output logic                           bypass,
    output logic                           log_sbit,
    output logic                           log_dbit,
    output logic [`ECC_MEM_AW-1:0]         log_adr,
    output logic                           clear_sbit,
    output logic                           clear_dbit,
    input  wire logic [`ECC_WB_DW-1:0]     sbit_cnt,
    input  wire logic [`ECC_WB_DW-1:0]     dbit_cnt,
    input  wire logic [`ECC_MEM_AW-1:0]    last_adr
);

    import ecc_mem_pkg::*;

    slave_state_t          state;
    logic [`ECC_MEM_AW:0]  adr_q;
    logic                  we_q;
    logic [12:0]           flip_data;
    logic [5:0]            flip_par;
    logic                  strobe;
    logic                  csr_hit;
    logic                  csr_wr;
    logic                  mem_rd_q;
    logic                  respond;
    logic [2:0]            reg_off;
    logic [`ECC_WB_DW-1:0] rd_data;

    assign strobe   = (state == IDLE) && wb_req.cyc && wb_req.stb;
    assign csr_hit  = wb_req.adr[`ECC_CSR_SEL];
    assign csr_wr   = strobe && csr_hit && wb_req.we;
    assign reg_off  = wb_req.adr[2:0];
    assign mem_rd_q = !adr_q[`ECC_CSR_SEL] && !we_q;
    assign respond  = (state == RESPOND);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            adr_q <= '0;
            we_q  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (strobe) begin
                        adr_q <= wb_req.adr;
                        we_q  <= wb_req.we;
                        state <= (!csr_hit && !wb_req.we) ? READ_WAIT : RESPOND;
                    end
                end
                READ_WAIT: state <= RESPOND; // array output settles.
                default:   state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bypass    <= 1'b0;
            flip_data <= '0;
            flip_par  <= '0;
        end else if (csr_wr) begin
            case (reg_off)
                `ECC_REG_CTRL:      bypass    <= wb_req.dat[0];
                `ECC_REG_FLIP_DATA: flip_data <= wb_req.dat[12:0];
                `ECC_REG_FLIP_PAR:  flip_par  <= wb_req.dat[5:0];
                default: ;
            endcase
        end
    end

    // writes land on the first edge straight from the bus.
    assign mem_we    = strobe && !csr_hit && wb_req.we;
    assign mem_adr   = (state == IDLE) ? wb_req.adr[`ECC_MEM_AW-1:0]
                                       : adr_q[`ECC_MEM_AW-1:0];
    assign enc_data  = wb_req.dat[12:0];
    assign mem_wdata = '{parity: enc_parity ^ flip_par, data: enc_data ^ flip_data};

    assign clear_sbit = csr_wr && (reg_off == `ECC_REG_SBIT_CNT);
    assign clear_dbit = csr_wr && (reg_off == `ECC_REG_DBIT_CNT);

    assign log_sbit = respond && mem_rd_q && dec_status.sbit;
    assign log_dbit = respond && mem_rd_q && dec_status.dbit;
    assign log_adr  = adr_q[`ECC_MEM_AW-1:0];

    always_comb begin
        rd_data = '0;
        if (adr_q[`ECC_CSR_SEL]) begin
            case (adr_q[2:0])
                `ECC_REG_CTRL:      rd_data[0]                = bypass;
                `ECC_REG_FLIP_DATA: rd_data[12:0]             = flip_data;
                `ECC_REG_FLIP_PAR:  rd_data[5:0]              = flip_par;
                `ECC_REG_SBIT_CNT:  rd_data                   = sbit_cnt;
                `ECC_REG_DBIT_CNT:  rd_data                   = dbit_cnt;
                `ECC_REG_LAST_ADR:  rd_data[`ECC_MEM_AW-1:0]  = last_adr;
                default: ;
            endcase
        end else begin
            rd_data[12:0] = dec_data; // upper bits stay zero.
        end
    end

    assign wb_rsp = '{ack: respond && !log_dbit, err: log_dbit, dat: rd_data};

    a_ack_err_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(wb_rsp.ack && wb_rsp.err)
    );

    a_rsp_in_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wb_rsp.ack || wb_rsp.err) |-> (wb_req.cyc && wb_req.stb)
    );

endmodule

`default_nettype wire
